// File: design/lfo_pkg.sv
/*
 * Shared types and register map for the LFO subsystem.
 * Imported by every LFO module that handles the configuration or output structs.
 */
package lfo_pkg;

    // waveform selection, encoding matches the wave register bits
    typedef enum logic [1:0] {
        wave_saw    = 2'd0,
        wave_square = 2'd1,
        wave_tri    = 2'd2,
        wave_noise  = 2'd3
    } lfo_wave_e;

    // triangle slope direction, one per channel
    typedef enum logic {
        dir_up   = 1'b0,
        dir_down = 1'b1
    } lfo_dir_e;

    // APB register offsets
    localparam logic [4:0] addr_freq = 5'h00;
    localparam logic [4:0] addr_amd  = 5'h04;
    localparam logic [4:0] addr_pmd  = 5'h08;
    localparam logic [4:0] addr_wave = 5'h0C;
    localparam logic [4:0] addr_ctrl = 5'h10; // bit 0 restarts the LFO

    // configuration as held by the register file, 24 bits
    typedef struct packed {
        logic [7:0] freq;  // octave in [7:4], fine rate in [3:0]
        logic [6:0] amd;   // amplitude-modulation depth
        logic [6:0] pmd;   // phase-modulation depth
        lfo_wave_e  wave;
    } lfo_cfg_t;

    // modulation values handed to the operator pipeline, 15 bits
    typedef struct packed {
        logic [6:0] am;    // unsigned
        logic [7:0] pm_u;  // sign in bit 7, inverted magnitude when negative
    } lfo_mod_t;

endpackage

// File: design/lfo_apb_regs.sv
/*
 * APB slave for the LFO configuration registers.
 * Writes land in cfg at the end of the access cycle; a control write
 * with bit 0 set gives a single-cycle restart pulse one cycle later.
 */
`timescale 1ns/1ps

module lfo_apb_regs
    import lfo_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output lfo_cfg_t    cfg,
    output logic        restart
);

    logic access;
    logic addr_hit;
    logic wr_en;

    assign access   = psel & penable;   // second cycle of a transfer
    assign addr_hit = paddr inside {addr_freq, addr_amd, addr_pmd, addr_wave, addr_ctrl};
    assign wr_en    = access & pwrite & addr_hit;

    assign pready  = 1'b1;              // zero wait states
    assign pslverr = access & ~addr_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg     <= '0;
            restart <= 1'b0;
        end else begin
            restart <= wr_en && (paddr == addr_ctrl) && pwdata[0];
            if (wr_en) begin
                case (paddr)
                    addr_freq: cfg.freq <= pwdata[7:0];
                    addr_amd:  cfg.amd  <= pwdata[6:0];
                    addr_pmd:  cfg.pmd  <= pwdata[6:0];
                    addr_wave: cfg.wave <= lfo_wave_e'(pwdata[1:0]);
                    default:   ;                            // ctrl holds no state
                endcase
            end
        end
    end

    // read mux, fields zero-extended to the bus width
    always_comb begin
        case (paddr)
            addr_freq: prdata = {24'd0, cfg.freq};
            addr_amd:  prdata = {25'd0, cfg.amd};
            addr_pmd:  prdata = {25'd0, cfg.pmd};
            addr_wave: prdata = {30'd0, cfg.wave};
            default:   prdata = 32'd0;                      // ctrl reads as zero
        endcase
    end

endmodule

// File: design/lfo_rate_gen.sv
/*
 * LFO rate generator. A base counter runs on the sample tick, the octave
 * nibble picks one of its bits, and each change of that bit is one LFO step.
 */
`timescale 1ns/1ps

module lfo_rate_gen
    import lfo_pkg::*;
#(
    parameter int base_lsb = 3
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       restart,
    input  logic       sample_tick,
    input  lfo_cfg_t   cfg,
    output logic       step,
    output logic [7:0] cnt_lim
);

    localparam int cnt_w = base_lsb + 16;

    logic [cnt_w-1:0] base_cnt;
    logic [4:0]       freq_sel;
    logic             sel_base;
    logic             last_base;

    // triangle runs one octave up so that a full cycle keeps the same period
    assign freq_sel = {1'b0, cfg.freq[7:4]} + {4'd0, cfg.wave == wave_tri};

    // octave 16 taps base_lsb-1, octave 0 taps the counter msb
    assign sel_base = base_cnt[base_lsb + 15 - int'(freq_sel)];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base_cnt  <= '0;
            last_base <= 1'b0;
            step      <= 1'b0;
        end else if (restart) begin
            base_cnt  <= '0;
            last_base <= 1'b0;
            step      <= 1'b0;
        end else begin
            if (sample_tick)
                base_cnt <= base_cnt + 1'b1;
            last_base <= sel_base;
            step      <= sel_base != last_base; // both edges of the tap count
        end
    end

    // fine rate, shorter period for higher nibble
    always_comb begin
        case (cfg.freq[3:0])
            4'h0: cnt_lim = 8'd128;
            4'h1: cnt_lim = 8'd120;
            4'h2: cnt_lim = 8'd114;
            4'h3: cnt_lim = 8'd108;
            4'h4: cnt_lim = 8'd102;
            4'h5: cnt_lim = 8'd98;
            4'h6: cnt_lim = 8'd93;
            4'h7: cnt_lim = 8'd89;
            4'h8: cnt_lim = 8'd85;
            4'h9: cnt_lim = 8'd82;
            4'hA: cnt_lim = 8'd79;
            4'hB: cnt_lim = 8'd76;
            4'hC: cnt_lim = 8'd73;
            4'hD: cnt_lim = 8'd70;
            4'hE: cnt_lim = 8'd68;
            default: cnt_lim = 8'd66;
        endcase
    end

endmodule

// File: design/lfo_noise_bit.sv
/*
 * One bit of LFO noise. A 17-bit Fibonacci shift register, x^17 + x^14 + 1,
 * loaded with its seed at reset and shifted once per LFO step.
 */
`timescale 1ns/1ps

module lfo_noise_bit #(
    parameter logic [16:0] noise_seed = 17'h1   // must be nonzero
) (
    input  logic clk,
    input  logic rst,
    input  logic step,
    output logic bit_out
);

    logic [16:0] lfsr;
    logic        fb;

    assign fb      = lfsr[16] ^ lfsr[13];   // maximal length taps
    assign bit_out = lfsr[16];

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            lfsr <= noise_seed;
        else if (step)
            lfsr <= {lfsr[15:0], fb};
    end

endmodule

// File: design/lfo_wave_gen.sv
/*
 * LFO waveform generator. On each step it advances the selected shape for
 * both channels: sawtooth, square, triangle or depth-masked noise.
 * Slopes use error accumulators so the ramp spans the depth in one period.
 */
`timescale 1ns/1ps

module lfo_wave_gen
    import lfo_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              restart,
    input  logic              step,
    input  lfo_cfg_t          cfg,
    input  logic [7:0]        cnt_lim,
    input  logic [6:0]        noise_am,
    input  logic [7:0]        noise_pm,
    output logic [6:0]        am_raw,
    output logic signed [7:0] pm
);

    logic [7:0]         sq_cnt;     // square half-period divider
    logic               sq_lvl;
    lfo_dir_e           am_dir;
    lfo_dir_e           pm_dir;
    logic signed [10:0] am_acc;
    logic signed [9:0]  pm_acc;
    logic signed [10:0] am_acc_mv;  // accumulator after a unit move
    logic signed [9:0]  pm_acc_mv;
    logic signed [7:0]  pmd_pos;
    logic signed [7:0]  pmd_neg;
    logic [6:0]         am_mask;
    logic [6:0]         pm_mask;
    logic [7:0]         pm_noise;

    // ones up to and including the highest set bit of the depth
    function automatic logic [6:0] depth_mask(input logic [6:0] depth);
        casez (depth)
            7'b1??????: return 7'b1111111;
            7'b01?????: return 7'b0111111;
            7'b001????: return 7'b0011111;
            7'b0001???: return 7'b0001111;
            7'b00001??: return 7'b0000111;
            7'b000001?: return 7'b0000011;
            7'b0000001: return 7'b0000001;
            default:    return 7'b0000000;
        endcase
    endfunction

    assign pmd_pos = $signed({1'b0, cfg.pmd});
    assign pmd_neg = -$signed({1'b0, cfg.pmd});

    // am spans 0..amd, pm spans twice as far, hence the doubled limit on am
    assign am_acc_mv = am_acc - $signed({2'b00, cnt_lim, 1'b0}) + $signed({4'b0000, cfg.amd});
    assign pm_acc_mv = pm_acc - $signed({2'b00, cnt_lim}) + $signed({3'b000, cfg.pmd});

    assign am_mask  = depth_mask(cfg.amd);
    assign pm_mask  = depth_mask(cfg.pmd);
    // unused upper bits copy the sign
    assign pm_noise = (pm_mask == 7'd0) ? 8'd0 :
                      {noise_pm[7], (noise_pm[6:0] & pm_mask) | ({7{noise_pm[7]}} & ~pm_mask)};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            am_raw <= '0;
            pm     <= '0;
            sq_cnt <= '0;
            sq_lvl <= 1'b0;
            am_dir <= dir_up;
            pm_dir <= dir_up;
            am_acc <= '0;
            pm_acc <= '0;
        end else if (restart) begin
            am_raw <= '0;
            pm     <= '0;
            sq_cnt <= '0;
            sq_lvl <= 1'b0;
            am_dir <= dir_up;
            pm_dir <= dir_up;
            am_acc <= '0;
            pm_acc <= '0;
        end else if (step) begin
            case (cfg.wave)
                wave_saw: begin
                    if (am_acc > 0) begin
                        if (am_raw == cfg.amd) begin    // wrap to bottom
                            am_raw <= '0;
                            am_acc <= '0;
                        end else begin
                            am_raw <= am_raw + 7'd1;
                            am_acc <= am_acc_mv;
                        end
                    end else begin
                        am_acc <= am_acc + $signed({4'b0000, cfg.amd});
                    end
                    if (pm_acc > 0) begin
                        if (pm == pmd_pos) begin        // wrap to -pmd
                            pm     <= pmd_neg;
                            pm_acc <= '0;
                        end else begin
                            pm     <= pm + 8'sd1;
                            pm_acc <= pm_acc_mv;
                        end
                    end else begin
                        pm_acc <= pm_acc + $signed({3'b000, cfg.pmd});
                    end
                end
                wave_square: begin
                    if (sq_cnt == cnt_lim) begin
                        sq_cnt <= '0;
                        sq_lvl <= ~sq_lvl;
                        am_raw <= sq_lvl ? cfg.amd : 7'd0;
                        pm     <= sq_lvl ? pmd_pos : pmd_neg;
                    end else begin
                        sq_cnt <= sq_cnt + 8'd1;
                    end
                end
                wave_tri: begin
                    if (am_acc > 0) begin
                        if (am_raw == cfg.amd && am_dir == dir_up) begin
                            am_dir <= dir_down;
                            am_acc <= '0;
                        end else if (am_raw == 7'd0 && am_dir == dir_down) begin
                            am_dir <= dir_up;
                            am_acc <= '0;
                        end else begin
                            am_raw <= (am_dir == dir_up) ? am_raw + 7'd1 : am_raw - 7'd1;
                            am_acc <= am_acc_mv;
                        end
                    end else begin
                        am_acc <= am_acc + $signed({4'b0000, cfg.amd});
                    end
                    if (pm_acc > 0) begin
                        if (pm == pmd_pos && pm_dir == dir_up) begin
                            pm_dir <= dir_down;
                            pm_acc <= '0;
                        end else if (pm == pmd_neg && pm_dir == dir_down) begin
                            pm_dir <= dir_up;
                            pm_acc <= '0;
                        end else begin
                            pm     <= (pm_dir == dir_up) ? pm + 8'sd1 : pm - 8'sd1;
                            pm_acc <= pm_acc_mv;
                        end
                    end else begin
                        pm_acc <= pm_acc + $signed({3'b000, cfg.pmd});
                    end
                end
                default: begin                          // noise
                    am_raw <= noise_am & am_mask;
                    pm     <= pm_noise;
                end
            endcase
        end
    end

endmodule

// File: design/lfo_out_stage.sv
/*
 * LFO output register. Captures am and the sign-magnitude form of pm on
 * each step edge and flags the new pair with a one-cycle mod_valid.
 */
`timescale 1ns/1ps

module lfo_out_stage
    import lfo_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              step,
    input  logic [6:0]        am_raw,
    input  logic signed [7:0] pm,
    output lfo_mod_t          mod,
    output logic              mod_valid
);

    logic [7:0] pm_u;

    // negative values keep the sign and invert the low bits
    assign pm_u = pm[7] ? {1'b1, ~pm[6:0]} : $unsigned(pm);

    // sampled on the step edge, so mod shows the level held before that step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mod       <= '0;
            mod_valid <= 1'b0;
        end else begin
            mod_valid <= step;
            if (step) begin
                mod.am   <= am_raw;
                mod.pm_u <= pm_u;
            end
        end
    end

endmodule

// File: design/lfo_top.sv
/*
 * LFO subsystem top level. APB configures rate, depths and waveform;
 * the AM and PM modulation values leave on mod, qualified by mod_valid.
 */
`timescale 1ns/1ps

module lfo_top
    import lfo_pkg::*;
#(
    parameter int base_lsb = 3
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        sample_tick,
    output lfo_mod_t    mod,
    output logic        mod_valid
);

    lfo_cfg_t          cfg;
    logic              restart;
    logic              step;
    logic [7:0]        cnt_lim;
    logic [6:0]        noise_am;
    logic [7:0]        noise_pm;
    logic [6:0]        am_raw;
    logic signed [7:0] pm;

    lfo_apb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg),
        .restart (restart)
    );

    lfo_rate_gen #(.base_lsb(base_lsb)) u_rate (
        .clk         (clk),
        .rst         (rst),
        .restart     (restart),
        .sample_tick (sample_tick),
        .cfg         (cfg),
        .step        (step),
        .cnt_lim     (cnt_lim)
    );

    // independent generators per bit, seeds kept apart and nonzero
    for (genvar i = 0; i < 7; i++) begin : g_am_noise
        lfo_noise_bit #(.noise_seed(17'(37 * i + 37))) u_noise_am (
            .clk     (clk),
            .rst     (rst),
            .step    (step),
            .bit_out (noise_am[i])
        );
    end

    for (genvar i = 0; i < 8; i++) begin : g_pm_noise
        lfo_noise_bit #(.noise_seed(17'(91 * i + 1091))) u_noise_pm (
            .clk     (clk),
            .rst     (rst),
            .step    (step),
            .bit_out (noise_pm[i])
        );
    end

    lfo_wave_gen u_wave (
        .clk      (clk),
        .rst      (rst),
        .restart  (restart),
        .step     (step),
        .cfg      (cfg),
        .cnt_lim  (cnt_lim),
        .noise_am (noise_am),
        .noise_pm (noise_pm),
        .am_raw   (am_raw),
        .pm       (pm)
    );

    lfo_out_stage u_out (
        .clk       (clk),
        .rst       (rst),
        .step      (step),
        .am_raw    (am_raw),
        .pm        (pm),
        .mod       (mod),
        .mod_valid (mod_valid)
    );

endmodule

// File: verification/lfo_sva.sv
/*
 * Assertions on the LFO top level, attached by bind.
 * Covers APB response rules and the output pulse and range.
 */
`timescale 1ns/1ps

module lfo_sva
    import lfo_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     psel,
    input logic     penable,
    input logic     pready,
    input logic     pslverr,
    input logic     mod_valid,
    input lfo_mod_t mod,
    input lfo_cfg_t cfg
);

    a_pready: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready went low");

    a_valid_pulse: assert property (@(posedge clk) disable iff (rst) mod_valid |=> !mod_valid)
        else $error("mod_valid held for two cycles");

    a_slverr_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> psel && penable)
        else $error("pslverr outside an access cycle");

    // noise mode masks by bit width, so it may exceed the depth value
    a_am_depth: assert property (@(posedge clk) disable iff (rst)
        mod_valid && cfg.wave != wave_noise |-> mod.am <= cfg.amd)
        else $error("am above depth");

endmodule

bind lfo_top lfo_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr),
    .mod_valid (mod_valid),
    .mod       (mod),
    .cfg       (cfg)
);

// File: verification/lfo_tb.sv
/*
 * Testbench for the LFO subsystem. Checks the APB registers, then runs a
 * table of waveform rows and checks every mod_valid against the shape rules.
 */
`timescale 1ns/1ps

module lfo_tb
    import lfo_pkg::*;
;
    localparam int n_rows = 5;

    logic        clk, rst, psel, penable, pwrite, sample_tick;
    logic [4:0]  paddr;
    logic [31:0] pwdata, prdata, rd;
    logic        pready, pslverr, err, mod_valid;
    lfo_mod_t    mod;
    int          errors, cycles, limit;
    logic [31:0] lfsr_state = 32'hd6ab;

    // row table: name, freq, amd, pmd (8'hFF = random), wave, steps, rule
    string      row_name  [n_rows] = '{"saw_ff", "square_ff", "tri_ff", "noise_f0", "saw_e5"};
    logic [7:0] row_freq  [n_rows] = '{8'hFF, 8'hFF, 8'hFF, 8'hF0, 8'hE5};
    logic [7:0] row_amd   [n_rows] = '{8'd20, 8'hFF, 8'd127, 8'hFF, 8'd9};
    logic [7:0] row_pmd   [n_rows] = '{8'd15, 8'hFF, 8'd40, 8'h13, 8'hFF};
    lfo_wave_e  row_wave  [n_rows] = '{wave_saw, wave_square, wave_tri, wave_noise, wave_saw};
    int         row_steps [n_rows] = '{200, 300, 320, 120, 150};
    int         row_rule  [n_rows] = '{0, 1, 2, 3, 0};  // 0 saw, 1 square, 2 tri, 3 noise

    lfo_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [6:0] take_bits(input int n);
        logic [6:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            val = {val[5:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [7:0] to_sm(input int v);
        return (v < 0) ? {1'b1, ~7'(v)} : 8'(v);
    endfunction

    function automatic int from_sm(input logic [7:0] u);
        return u[7] ? -1 - int'(u[6:0]) : int'(u[6:0]);
    endfunction

    function automatic logic [6:0] top_mask(input logic [6:0] d);
        logic [6:0] m;
        m = '0;
        for (int i = 0; i < 7; i++)
            if (d[i]) m = 7'((1 << (i + 1)) - 1);
        return m;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [4:0] a, input logic [31:0] d,
                            output logic [31:0] data, output logic slverr);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(negedge clk);
        penable = 1'b1;
        #1;                                         // access cycle, before the edge
        data   = prdata;
        slverr = pslverr;
        check("apb/pready", 1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic run_row(input int r);
        logic [6:0] amd, pmd, am, prev;
        int         n, pv, ppv;
        bit         first, level_seen, seen_top, seen_both;
        string      nm;
        nm  = row_name[r];
        amd = (row_amd[r] == 8'hFF) ? (take_bits(7) | 7'h04) : row_amd[r][6:0];
        pmd = (row_pmd[r] == 8'hFF) ? (take_bits(7) | 7'h04) : row_pmd[r][6:0];
        apb_xfer(1'b1, addr_ctrl, 32'd1, rd, err);  // park state at 0 before mode change
        apb_xfer(1'b1, addr_freq, row_freq[r], rd, err);
        apb_xfer(1'b1, addr_wave, row_wave[r], rd, err);
        apb_xfer(1'b1, addr_amd, amd, rd, err);
        apb_xfer(1'b1, addr_pmd, pmd, rd, err);
        apb_xfer(1'b1, addr_ctrl, 32'd1, rd, err);
        repeat (3) @(negedge clk);
        sample_tick = 1'b1;
        n          = 0;
        first      = 1;
        prev       = 0;
        ppv        = 0;
        level_seen = 0;
        seen_top   = 0;
        seen_both  = 0;
        while (n < row_steps[r]) begin
            @(negedge clk);
            if (mod_valid) begin
                n++;
                am = mod.am;
                pv = from_sm(mod.pm_u);
                if (first) check({nm, "/first"}, 0, {mod.am, mod.pm_u});
                if (row_rule[r] != 3)
                    check({nm, "/pm_range"}, 1, pv >= -int'(pmd) && pv <= int'(pmd));
                case (row_rule[r])
                    0: begin
                        check({nm, "/am_max"}, 1, am <= amd);
                        if (am != prev) check({nm, "/am_ramp"}, 1, am == prev + 1 || am == 0);
                        if (pv != ppv)
                            check({nm, "/pm_ramp"}, 1, pv == ppv + 1 || pv == -int'(pmd));
                    end
                    1: begin
                        check({nm, "/level"}, 1, (am == 0 && pv == 0 && !level_seen) ||
                              (am == 0 && pv == -int'(pmd)) || (am == amd && pv == int'(pmd)));
                        if (pv != 0) level_seen = 1;
                    end
                    2: begin
                        check({nm, "/am_max"}, 1, am <= amd);
                        check({nm, "/am_slope"}, 1, int'(am) - int'(prev) <= 1 &&
                              int'(prev) - int'(am) <= 1);
                        check({nm, "/pm_slope"}, 1, pv - ppv <= 1 && ppv - pv <= 1);
                        if (am == amd) seen_top = 1;
                        if (seen_top && am == 0) seen_both = 1;
                    end
                    default: begin
                        check({nm, "/am_mask"}, 0, am & ~top_mask(amd));
                        check({nm, "/pm_mask"}, 0, mod.pm_u[6:0] & ~top_mask(pmd));
                    end
                endcase
                prev  = am;
                ppv   = pv;
                first = 0;
            end
        end
        sample_tick = 1'b0;
        if (row_rule[r] == 2) check({nm, "/ends"}, 1, seen_both);
    endtask

    logic [4:0]  reg_addr [4] = '{addr_freq, addr_amd, addr_pmd, addr_wave};
    logic [31:0] reg_wr   [4] = '{32'hFFFF_FFA5, 32'h0000_00FF, 32'h1234_5655, 32'hFFFF_FFFE};
    logic [31:0] reg_exp  [4] = '{32'hA5, 32'h7F, 32'h55, 32'h2};

    initial begin
        int total, maxp, p;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        sample_tick = 1'b0;
        errors      = 0;
        cycles      = 0;
        total       = 0;
        maxp        = 0;
        for (int r = 0; r < n_rows; r++) begin
            p = 1 << (18 - int'(row_freq[r][7:4]) - int'(row_wave[r] == wave_tri));
            if (p > maxp) maxp = p;
            total += row_steps[r];
        end
        limit = total * maxp + 3000;                // margin covers reset and APB traffic
        repeat (10) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        check("reset/outputs", 0, {mod_valid, mod, pslverr});

        for (int i = 0; i < 4; i++) apb_xfer(1'b1, reg_addr[i], reg_wr[i], rd, err);
        apb_xfer(1'b1, 5'h14, 32'h0000_0000, rd, err);
        check("apb/unmapped_err", 1, err);
        apb_xfer(1'b0, addr_ctrl, 32'd0, rd, err);
        check("apb/ctrl_read", 0, rd);
        for (int i = 0; i < 4; i++) begin
            apb_xfer(1'b0, reg_addr[i], 32'd0, rd, err);
            check("apb/readback", reg_exp[i], rd);
            check("apb/read_err", 0, err);
        end

        for (int r = 0; r < n_rows; r++) run_row(r);

        $display("run complete with %0d errors", errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: flist.f
design/lfo_pkg.sv
design/lfo_apb_regs.sv
design/lfo_rate_gen.sv
design/lfo_noise_bit.sv
design/lfo_wave_gen.sv
design/lfo_out_stage.sv
design/lfo_top.sv
verification/lfo_sva.sv
verification/lfo_tb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = lfo_tb
FLIST = flist.f
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
